/* mem_pipe_pkg.sv */
package mem_pipe_pkg;

  typedef enum logic [1:0] {
    OP_ALU   = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2
  } op_kind_e;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } mem_size_e;

  typedef struct packed {
    op_kind_e    kind;
    mem_size_e   size;
    logic        load_unsigned;
    logic [63:0] base;
    logic [63:0] imm;
    logic [63:0] store_data;
    logic [4:0]  rd;
    logic        rd_wr_ena;
  } issue_t;

  // byte address split into 64-bit word and lane
  typedef struct packed {
    logic [60:0] word_index;
    logic [2:0]  byte_off;
  } mem_addr_t;

  // one word read as an alu result or as a memory address
  typedef union packed {
    logic [63:0] alu_value;
    mem_addr_t   addr;
  } ex_result_u;

  typedef struct packed {
    op_kind_e    kind;
    mem_size_e   size;
    logic        load_unsigned;
    ex_result_u  result;
    logic [63:0] store_data;
    logic [4:0]  rd;
    logic        rd_wr_ena;
    logic        misaligned;
  } ex_to_mem_t;

  typedef struct packed {
    op_kind_e    kind;
    logic [4:0]  rd;
    logic        rd_wr_ena;
    logic [63:0] ex_data;
    logic [63:0] load_data;
    logic        misaligned;
  } mem_to_wb_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic        rd_wr_ena;
    logic [63:0] wr_data;
    logic        misaligned;
  } retire_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic        rd_wr_ena;
    logic        is_load;
    logic [63:0] ex_data;
  } forward_t;

  typedef struct packed {
    logic        write;
    logic [63:0] addr;
    mem_size_e   size;
    logic [63:0] wdata;
  } ram_req_t;

endpackage

/* agu_stage.sv */
`timescale 1ns/10ps

module agu_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     issue_valid,
  input  mem_pipe_pkg::issue_t     issue,
  output logic                     issue_allowin,
  output logic                     ex_valid,
  output mem_pipe_pkg::ex_to_mem_t ex_bus,
  input  logic                     mem_allowin
);
  import mem_pipe_pkg::*;

  logic [63:0] eff_addr;
  logic        is_mem;
  logic        misaligned;
  ex_to_mem_t  ex_next;

  assign eff_addr = issue.base + issue.imm;
  assign is_mem   = (issue.kind == OP_LOAD) || (issue.kind == OP_STORE);

  // offset must be a multiple of the access size
  always_comb begin
    case (issue.size)
      SIZE_H:  misaligned = is_mem && eff_addr[0];
      SIZE_W:  misaligned = is_mem && (|eff_addr[1:0]);
      SIZE_D:  misaligned = is_mem && (|eff_addr[2:0]);
      default: misaligned = 1'b0;
    endcase
  end

  always_comb begin
    ex_next.kind          = issue.kind;
    ex_next.size          = issue.size;
    ex_next.load_unsigned = issue.load_unsigned;
    ex_next.store_data    = issue.store_data;
    ex_next.rd            = issue.rd;
    ex_next.rd_wr_ena     = issue.rd_wr_ena;
    ex_next.misaligned    = misaligned;
    if (is_mem) begin
      ex_next.result.addr.word_index = eff_addr[63:3];
      ex_next.result.addr.byte_off   = eff_addr[2:0];
    end else begin
      // alu ops carry their result in base
      ex_next.result.alu_value = issue.base;
    end
  end

  // free when empty or when the memory stage takes the op
  assign issue_allowin = !ex_valid || mem_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (issue_allowin) begin
      ex_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid && issue_allowin) begin
      ex_bus <= ex_next;
    end
  end

endmodule

/* mem_stage.sv */
`timescale 1ns/10ps

module mem_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ex_valid,
  input  mem_pipe_pkg::ex_to_mem_t ex_bus,
  output logic                     mem_allowin,
  output logic                     wb_valid,
  output mem_pipe_pkg::mem_to_wb_t wb_bus,
  input  logic                     wb_allowin,
  output mem_pipe_pkg::forward_t   mem_forward,
  output logic                     ram_valid,
  output mem_pipe_pkg::ram_req_t   ram_req,
  input  logic                     ram_ready,
  input  logic [63:0]              ram_rdata
);
  import mem_pipe_pkg::*;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    ADDR = 2'd1,
    RETN = 2'd2
  } mem_state_e;

  mem_state_e  state;
  mem_state_e  state_next;
  logic        mem_valid;
  ex_to_mem_t  bus_r;
  logic        ready_go;
  logic        accept;
  logic        handshake;
  logic        ex_is_mem;
  logic        r_is_mem;
  logic [5:0]  lane_shift;
  logic [63:0] rdata_shifted;
  logic [63:0] load_ext;
  logic [63:0] load_data;
  logic [63:0] size_mask;

  assign ex_is_mem = ((ex_bus.kind == OP_LOAD) || (ex_bus.kind == OP_STORE)) &&
                     !ex_bus.misaligned;
  assign r_is_mem  = ((bus_r.kind == OP_LOAD) || (bus_r.kind == OP_STORE)) &&
                     !bus_r.misaligned;

  assign ready_go    = !r_is_mem || (state == RETN);
  assign mem_allowin = !mem_valid || (ready_go && wb_allowin);
  assign wb_valid    = mem_valid && ready_go;
  assign accept      = ex_valid && mem_allowin;
  assign handshake   = ram_valid && ram_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid <= 1'b0;
    end else if (mem_allowin) begin
      mem_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      bus_r <= ex_bus;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (accept && ex_is_mem) state_next = ADDR;
      ADDR: if (handshake) state_next = RETN;
      // back to back memory ops skip idle
      RETN: if (wb_allowin) state_next = (accept && ex_is_mem) ? ADDR : IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_comb begin
    case (bus_r.size)
      SIZE_B:  size_mask = 64'h0000_0000_0000_00ff;
      SIZE_H:  size_mask = 64'h0000_0000_0000_ffff;
      SIZE_W:  size_mask = 64'h0000_0000_ffff_ffff;
      default: size_mask = 64'hffff_ffff_ffff_ffff;
    endcase
  end

  assign lane_shift = {bus_r.result.addr.byte_off, 3'b000};

  assign ram_valid     = (state == ADDR);
  assign ram_req.write = (bus_r.kind == OP_STORE);
  assign ram_req.addr  = bus_r.result.alu_value;
  assign ram_req.size  = bus_r.size;
  assign ram_req.wdata = (bus_r.store_data & size_mask) << lane_shift;

  // bring the addressed lane down to bit 0
  assign rdata_shifted = ram_rdata >> lane_shift;

  always_comb begin
    case (bus_r.size)
      SIZE_B: load_ext = bus_r.load_unsigned ? {56'b0, rdata_shifted[7:0]}
                                             : {{56{rdata_shifted[7]}}, rdata_shifted[7:0]};
      SIZE_H: load_ext = bus_r.load_unsigned ? {48'b0, rdata_shifted[15:0]}
                                             : {{48{rdata_shifted[15]}}, rdata_shifted[15:0]};
      SIZE_W: load_ext = bus_r.load_unsigned ? {32'b0, rdata_shifted[31:0]}
                                             : {{32{rdata_shifted[31]}}, rdata_shifted[31:0]};
      default: load_ext = rdata_shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (handshake) begin
      load_data <= load_ext;
    end
  end

  assign wb_bus.kind       = bus_r.kind;
  assign wb_bus.rd         = bus_r.rd;
  assign wb_bus.rd_wr_ena  = bus_r.rd_wr_ena;
  assign wb_bus.ex_data    = bus_r.result.alu_value;
  assign wb_bus.load_data  = load_data;
  assign wb_bus.misaligned = bus_r.misaligned;

  // write enable as writeback will see it
  assign mem_forward.valid     = mem_valid;
  assign mem_forward.rd        = bus_r.rd;
  assign mem_forward.rd_wr_ena = bus_r.rd_wr_ena && (bus_r.kind != OP_STORE) &&
                                 !bus_r.misaligned;
  assign mem_forward.is_load   = (bus_r.kind == OP_LOAD);
  assign mem_forward.ex_data   = bus_r.result.alu_value;

endmodule

/* data_ram.sv */
`timescale 1ns/10ps

module data_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ram_valid,
  input  mem_pipe_pkg::ram_req_t ram_req,
  output logic                   ram_ready,
  output logic [63:0]            ram_rdata
);
  import mem_pipe_pkg::*;

  localparam int IDX_W = $clog2(RAM_WORDS);

  logic [63:0]      mem [RAM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [7:0]       byte_en;
  logic [7:0]       lfsr;
  logic             busy;
  logic [1:0]       wait_cnt;
  logic             handshake;

  // word index wraps at the array size
  assign idx = ram_req.addr[IDX_W+2:3];

  always_comb begin
    case (ram_req.size)
      SIZE_B:  byte_en = 8'h01 << ram_req.addr[2:0];
      SIZE_H:  byte_en = 8'h03 << ram_req.addr[2:0];
      SIZE_W:  byte_en = 8'h0f << ram_req.addr[2:0];
      default: byte_en = 8'hff;
    endcase
  end

  // delay of 0 answers in the request cycle itself
  assign ram_ready = ram_valid && (busy ? (wait_cnt == 2'd0) : (lfsr[1:0] == 2'd0));
  assign handshake = ram_valid && ram_ready;
  assign ram_rdata = mem[idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr     <= 8'h5a;
      busy     <= 1'b0;
      wait_cnt <= 2'd0;
    end else begin
      // x^8 + x^6 + x^5 + x^4 + 1
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
      if (handshake) begin
        busy <= 1'b0;
      end else if (ram_valid && !busy) begin
        busy     <= 1'b1;
        wait_cnt <= lfsr[1:0] - 2'd1;
      end else if (busy && (wait_cnt != 2'd0)) begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < RAM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (handshake && ram_req.write) begin
      for (int b = 0; b < 8; b++) begin
        if (byte_en[b]) begin
          mem[idx][8*b +: 8] <= ram_req.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

/* wb_stage.sv */
`timescale 1ns/10ps

module wb_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wb_valid,
  input  mem_pipe_pkg::mem_to_wb_t wb_bus,
  output logic                     wb_allowin,
  output logic                     retire_valid,
  output mem_pipe_pkg::retire_t    retire,
  input  logic                     retire_allowin
);
  import mem_pipe_pkg::*;

  retire_t retire_next;
  logic    is_load;

  assign is_load = (wb_bus.kind == OP_LOAD) && !wb_bus.misaligned;

  always_comb begin
    retire_next.rd         = wb_bus.rd;
    // stores and faulting ops never write the register file
    retire_next.rd_wr_ena  = wb_bus.rd_wr_ena && (wb_bus.kind != OP_STORE) &&
                             !wb_bus.misaligned;
    retire_next.wr_data    = is_load ? wb_bus.load_data : wb_bus.ex_data;
    retire_next.misaligned = wb_bus.misaligned;
  end

  assign wb_allowin = !retire_valid || retire_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
    end else if (wb_allowin) begin
      retire_valid <= wb_valid;
    end
  end

  // record held while the consumer stalls
  always_ff @(posedge clk) begin
    if (wb_valid && wb_allowin) begin
      retire <= retire_next;
    end
  end

endmodule

/* mem_pipe_top.sv */
`timescale 1ns/10ps

module mem_pipe_top #(
  parameter int RAM_WORDS = 256
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   issue_valid,
  input  mem_pipe_pkg::issue_t   issue,
  output logic                   issue_allowin,
  output logic                   retire_valid,
  output mem_pipe_pkg::retire_t  retire,
  input  logic                   retire_allowin,
  output mem_pipe_pkg::forward_t mem_forward
);
  import mem_pipe_pkg::*;

  logic        ex_valid;
  ex_to_mem_t  ex_bus;
  logic        mem_allowin;
  logic        wb_valid;
  mem_to_wb_t  wb_bus;
  logic        wb_allowin;
  logic        ram_valid;
  ram_req_t    ram_req;
  logic        ram_ready;
  logic [63:0] ram_rdata;

  agu_stage agu_i (
    .clk           (clk),
    .rst           (rst),
    .issue_valid   (issue_valid),
    .issue         (issue),
    .issue_allowin (issue_allowin),
    .ex_valid      (ex_valid),
    .ex_bus        (ex_bus),
    .mem_allowin   (mem_allowin)
  );

  mem_stage mem_i (
    .clk         (clk),
    .rst         (rst),
    .ex_valid    (ex_valid),
    .ex_bus      (ex_bus),
    .mem_allowin (mem_allowin),
    .wb_valid    (wb_valid),
    .wb_bus      (wb_bus),
    .wb_allowin  (wb_allowin),
    .mem_forward (mem_forward),
    .ram_valid   (ram_valid),
    .ram_req     (ram_req),
    .ram_ready   (ram_ready),
    .ram_rdata   (ram_rdata)
  );

  data_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) ram_i (
    .clk       (clk),
    .rst       (rst),
    .ram_valid (ram_valid),
    .ram_req   (ram_req),
    .ram_ready (ram_ready),
    .ram_rdata (ram_rdata)
  );

  wb_stage wb_i (
    .clk            (clk),
    .rst            (rst),
    .wb_valid       (wb_valid),
    .wb_bus         (wb_bus),
    .wb_allowin     (wb_allowin),
    .retire_valid   (retire_valid),
    .retire         (retire),
    .retire_allowin (retire_allowin)
  );

endmodule

/* mem_pipe_sva.sv */
`timescale 1ns/10ps

module mem_pipe_sva (
  input logic                   clk,
  input logic                   rst,
  input logic                   issue_valid,
  input logic                   issue_allowin,
  input logic                   retire_valid,
  input mem_pipe_pkg::retire_t  retire,
  input logic                   retire_allowin,
  input mem_pipe_pkg::forward_t mem_forward,
  input logic                   ram_valid,
  input mem_pipe_pkg::ram_req_t ram_req,
  input logic                   ram_ready
);

  logic [2:0] in_flight;
  logic       hold_fail   = 1'b0;
  logic       reset_fail  = 1'b0;
  logic       ram_fail    = 1'b0;
  logic       flight_fail = 1'b0;
  logic       any_fail;

  assign any_fail = hold_fail || reset_fail || ram_fail || flight_fail;

  // operations accepted at issue and not yet retired
  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= 3'd0;
    end else begin
      in_flight <= in_flight + {2'b0, issue_valid && issue_allowin}
                             - {2'b0, retire_valid && retire_allowin};
    end
  end

  retire_held: assert property (@(posedge clk) disable iff (rst)
    retire_valid && !retire_allowin |=> retire_valid && $stable(retire))
    else begin
      hold_fail = 1'b1;
      $error("retire record changed while the consumer stalled");
    end

  reset_state: assert property (@(posedge clk)
    rst |=> !retire_valid && issue_allowin && !mem_forward.valid && !ram_valid)
    else begin
      reset_fail = 1'b1;
      $error("outputs not in their reset state after reset");
    end

  ram_req_held: assert property (@(posedge clk) disable iff (rst)
    ram_valid && !ram_ready |=> ram_valid && $stable(ram_req))
    else begin
      ram_fail = 1'b1;
      $error("ram request dropped or changed before ready");
    end

  // one op per stage at most, and nothing retires that was never issued
  flight_bound: assert property (@(posedge clk) disable iff (rst)
    (in_flight <= 3'd3) && (!retire_valid || (in_flight != 3'd0)))
    else begin
      flight_fail = 1'b1;
      $error("operation count in flight out of range");
    end

endmodule

bind mem_pipe_top mem_pipe_sva sva_i (
  .clk            (clk),
  .rst            (rst),
  .issue_valid    (issue_valid),
  .issue_allowin  (issue_allowin),
  .retire_valid   (retire_valid),
  .retire         (retire),
  .retire_allowin (retire_allowin),
  .mem_forward    (mem_forward),
  .ram_valid      (ram_valid),
  .ram_req        (ram_req),
  .ram_ready      (ram_ready)
);

/* mem_pipe_tb.sv */
`timescale 1ns/10ps

module mem_pipe_tb;
  import mem_pipe_pkg::*;

  localparam int RAM_WORDS   = 256;
  localparam int NUM_OPS     = 400;
  localparam int WATCHDOG_NS = 4 * (10 + NUM_OPS * 40);

  logic        clk;
  logic        rst;
  logic        issue_valid;
  issue_t      issue;
  logic        issue_allowin;
  logic        retire_valid;
  retire_t     retire;
  logic        retire_allowin;
  forward_t    mem_forward;

  logic [63:0] shadow [RAM_WORDS];
  retire_t     exp_q [$];
  forward_t    fwd_q [$];
  retire_t     want;
  forward_t    fwd_want;
  int          fwd_pos;

  mem_pipe_top #(
    .RAM_WORDS (RAM_WORDS)
  ) dut_i (
    .clk            (clk),
    .rst            (rst),
    .issue_valid    (issue_valid),
    .issue          (issue),
    .issue_allowin  (issue_allowin),
    .retire_valid   (retire_valid),
    .retire         (retire),
    .retire_allowin (retire_allowin),
    .mem_forward    (mem_forward)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic report_value_error(input string name, input logic [63:0] got,
                                    input logic [63:0] expected);
    $display("[ERROR] %s got %h expected %h", name, got, expected);
    stop_with_failure();
  endtask

  // pick the addressed bytes out of a word and extend them
  function automatic logic [63:0] extract_load(logic [63:0] word, int unsigned off,
                                               int unsigned nbytes, logic uns);
    logic [63:0] v;
    logic        sign;
    v = '0;
    for (int unsigned i = 0; i < 8; i++) begin
      if ((i < nbytes) && (off + i < 8)) begin
        v[8*i +: 8] = word[8*(off+i) +: 8];
      end
    end
    sign = !uns && v[8*nbytes-1];
    for (int unsigned i = 0; i < 8; i++) begin
      if (i >= nbytes) begin
        v[8*i +: 8] = {8{sign}};
      end
    end
    return v;
  endfunction

  task automatic predict_retire(input issue_t op);
    logic [63:0] addr;
    int unsigned nbytes;
    int unsigned off;
    int unsigned idx;
    logic        bad;
    retire_t     exp_rec;
    forward_t    exp_fwd;
    addr   = op.base + op.imm;
    nbytes = 32'd1 << op.size;
    off    = {29'b0, addr[2:0]};
    idx    = 32'((addr >> 3) % RAM_WORDS);
    bad    = (op.kind != OP_ALU) && ((off % nbytes) != 0);
    exp_rec.rd         = op.rd;
    exp_rec.misaligned = bad;
    exp_rec.rd_wr_ena  = op.rd_wr_ena && (op.kind != OP_STORE) && !bad;
    if (op.kind == OP_ALU) begin
      exp_rec.wr_data = op.base;
    end else if ((op.kind == OP_LOAD) && !bad) begin
      exp_rec.wr_data = extract_load(shadow[idx], off, nbytes, op.load_unsigned);
    end else begin
      // stores and faulting ops hand back their address
      exp_rec.wr_data = addr;
    end
    if ((op.kind == OP_STORE) && !bad) begin
      for (int unsigned i = 0; i < nbytes; i++) begin
        shadow[idx][8*(off+i) +: 8] = op.store_data[8*i +: 8];
      end
    end
    exp_fwd.valid     = 1'b1;
    exp_fwd.rd        = op.rd;
    exp_fwd.rd_wr_ena = exp_rec.rd_wr_ena;
    exp_fwd.is_load   = (op.kind == OP_LOAD);
    exp_fwd.ex_data   = (op.kind == OP_ALU) ? op.base : addr;
    exp_q.push_back(exp_rec);
    fwd_q.push_back(exp_fwd);
  endtask

  task automatic make_random_op(output issue_t op);
    logic [63:0] word;
    logic [63:0] target;
    int unsigned roll;
    roll             = $urandom_range(0, 9);
    op.kind          = (roll < 3) ? OP_ALU : ((roll < 6) ? OP_LOAD : OP_STORE);
    op.size          = mem_size_e'(2'($urandom_range(0, 3)));
    op.load_unsigned = (op.size != SIZE_D) && ($urandom_range(0, 1) == 1);
    op.store_data    = {$urandom(), $urandom()};
    op.rd            = 5'($urandom_range(0, 31));
    op.rd_wr_ena     = ($urandom_range(0, 7) != 0);
    // a narrow window now and then so loads hit earlier stores
    if ($urandom_range(0, 1) == 1) begin
      word = 64'($urandom_range(0, 15));
    end else begin
      word = 64'($urandom_range(0, RAM_WORDS - 1));
    end
    target = (word << 3) + 64'($urandom_range(0, 7));
    if ($urandom_range(0, 7) != 0) begin
      target = target & ~((64'd1 << op.size) - 64'd1);
    end
    op.imm  = 64'($urandom_range(0, 64)) - 64'd32;
    op.base = target - op.imm;
    if (op.kind == OP_ALU) begin
      op.base = {$urandom(), $urandom()};
    end
  endtask

  task automatic drive_op(input issue_t op);
    @(negedge clk);
    issue_valid = 1'b1;
    issue       = op;
    @(posedge clk);
    while (!issue_allowin) begin
      @(posedge clk);
    end
    predict_retire(op);
    if ($urandom_range(0, 3) == 0) begin
      @(negedge clk);
      issue_valid = 1'b0;
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      retire_allowin = ($urandom_range(0, 3) != 0);
    end
  end

  // every retire transfer is matched against the oldest prediction
  always @(posedge clk) begin
    if (!rst && mem_forward.valid) begin
      // an op held in writeback sits ahead of the memory stage
      fwd_pos = retire_valid ? 1 : 0;
      if (fwd_q.size() <= fwd_pos) begin
        $display("the memory stage holds an operation that was never issued");
        stop_with_failure();
      end else begin
        fwd_want = fwd_q[fwd_pos];
        assert (mem_forward.rd == fwd_want.rd)
          else report_value_error("mem_forward.rd", {59'b0, mem_forward.rd},
                                  {59'b0, fwd_want.rd});
        assert (mem_forward.rd_wr_ena == fwd_want.rd_wr_ena)
          else report_value_error("mem_forward.rd_wr_ena", {63'b0, mem_forward.rd_wr_ena},
                                  {63'b0, fwd_want.rd_wr_ena});
        assert (mem_forward.is_load == fwd_want.is_load)
          else report_value_error("mem_forward.is_load", {63'b0, mem_forward.is_load},
                                  {63'b0, fwd_want.is_load});
        assert (mem_forward.ex_data == fwd_want.ex_data)
          else report_value_error("mem_forward.ex_data", mem_forward.ex_data,
                                  fwd_want.ex_data);
      end
    end
    if (!rst && retire_valid && retire_allowin) begin
      if (exp_q.size() == 0) begin
        $display("a retire arrived with no operation outstanding");
        stop_with_failure();
      end else begin
        want = exp_q.pop_front();
        void'(fwd_q.pop_front());
        assert (retire.rd == want.rd)
          else report_value_error("retire.rd", {59'b0, retire.rd}, {59'b0, want.rd});
        assert (retire.rd_wr_ena == want.rd_wr_ena)
          else report_value_error("retire.rd_wr_ena", {63'b0, retire.rd_wr_ena},
                                  {63'b0, want.rd_wr_ena});
        assert (retire.misaligned == want.misaligned)
          else report_value_error("retire.misaligned", {63'b0, retire.misaligned},
                                  {63'b0, want.misaligned});
        assert (retire.wr_data == want.wr_data)
          else report_value_error("retire.wr_data", retire.wr_data, want.wr_data);
      end
    end
  end

  always @(negedge clk) begin
    if (dut_i.sva_i.any_fail) begin
      $display("a protocol assertion in the bound checker failed");
      stop_with_failure();
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the operations did not all retire in time");
    stop_with_failure();
  end

  initial begin
    issue_t op;
    void'($urandom(32'h93f5_f395));
    rst            = 1'b1;
    issue_valid    = 1'b0;
    issue          = '0;
    retire_allowin = 1'b0;
    for (int w = 0; w < RAM_WORDS; w++) begin
      shadow[w] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < NUM_OPS; n++) begin
      make_random_op(op);
      drive_op(op);
    end
    @(negedge clk);
    issue_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    if (!retire_valid && !mem_forward.valid) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("operations left in the pipeline after the last expected retire");
      stop_with_failure();
    end
  end

endmodule

/* rv64_mem_pipe.f */
mem_pipe_pkg.sv
agu_stage.sv
mem_stage.sv
data_ram.sv
wb_stage.sv
mem_pipe_top.sv
mem_pipe_sva.sv
mem_pipe_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_pipe_tb
FILELIST  ?= rv64_mem_pipe.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Test completed successfully

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
